// File: sim.f
+incdir+hw
hw/io_pkg.sv
hw/hex_display.sv
hw/interval_timer.sv
hw/lcd_controller.sv
hw/io_handler.sv
test/io_handler_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the io_handler testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module io_handler_tb -Mdir "$build_dir" -o io_handler_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/io_handler_tb" 2>&1 | tee "$log_file"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$log_file"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $log_file"
exit 1

// File: test/io_handler_tb.sv
`timescale 1ns/1ps
`include "io_defs.svh"

module io_handler_tb;
    import io_pkg::*;

    // 1500 random accesses plus at most 40 LCD writes of 36 cycles each, with margin
    localparam int CYCLE_LIMIT = 20000;
    localparam int LCD_TOTAL   = `LCD_SETUP + `LCD_PULSE + `LCD_HOLD;

    logic        clock;
    logic        reset;
    logic [9:0]  sw;
    logic        io_select;
    logic        strobe;
    logic        write;
    logic [31:0] address;
    logic [31:0] write_data;
    logic [31:0] read_data;
    logic [8:0]  led;
    seg_t        hex [6];
    logic [7:0]  lcd_data;
    logic        lcd_rs;
    logic        lcd_e;
    logic        irq;

    logic [31:0] rng_state;
    int          errors = 0;
    int          cycles = 0;
    seg_t        seg_table [16];
    logic [15:0] offsets [7];
    logic [8:0]  m_led;
    logic [23:0] m_hex;
    logic [31:0] m_reload;
    logic [31:0] m_count;
    timer_ctrl_t m_ctrl;
    logic        m_irq;
    logic        m_lcd_active;
    int          m_lcd_age;        // edges since the write was latched
    logic [8:0]  m_lcd_latched;    // {rs, data} of the write in progress
    logic [8:0]  accepted [$];
    int          accepted_count = 0;
    int          pulse_count = 0;
    logic        last_e;

    io_handler dut0 (
        .clock      (clock),
        .reset      (reset),
        .sw         (sw),
        .io_select  (io_select),
        .strobe     (strobe),
        .write      (write),
        .address    (address),
        .write_data (write_data),
        .read_data  (read_data),
        .led        (led),
        .hex0       (hex[0]),
        .hex1       (hex[1]),
        .hex2       (hex[2]),
        .hex3       (hex[3]),
        .hex4       (hex[4]),
        .hex5       (hex[5]),
        .lcd_data   (lcd_data),
        .lcd_rs     (lcd_rs),
        .lcd_e      (lcd_e),
        .irq        (irq)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run not finished after %0d cycles, %0d errors so far",
                     CYCLE_LIMIT, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int unsigned random_below(input int unsigned n);
        logic [31:0] r;
        r = next_random();
        return (r >> 8) % n;   // low LCG bits have short periods
    endfunction

    function automatic lcd_state_e lcd_phase(input logic active, input int age);
        if (!active) begin
            return idle;
        end else if (age < `LCD_SETUP) begin
            return setup;
        end else if (age < `LCD_SETUP + `LCD_PULSE) begin
            return pulse;
        end
        return hold;
    endfunction

    function automatic logic is_mapped(input logic [15:0] a);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 7; k++) begin
            hit = hit || (a == offsets[k]);
        end
        return hit;
    endfunction

    function automatic logic [31:0] expected_read();
        logic [31:0] value;
        value = 32'd0;
        if (io_select && strobe && !write) begin
            case (address[15:0])
                `IO_SW_ADDR:       value = {22'd0, sw};
                `IO_LCD_CMD_ADDR:  value = {31'd0, m_lcd_active};
                `IO_TMR_DATA_ADDR: value = m_count;
                `IO_TMR_CTRL_ADDR: value = {28'd0, m_ctrl};
                default:           value = 32'd0;
            endcase
        end
        return value;
    endfunction

    // next register state from the current state and the bus inputs of this cycle
    function automatic void advance_model();
        logic        wr;
        logic [15:0] a;
        logic        expired;
        timer_ctrl_t next_ctrl;
        wr = io_select && strobe && write;
        a = address[15:0];
        expired = m_ctrl.run && (m_count == 32'd0);
        m_irq = m_ctrl.pending && m_ctrl.irq_en;
        next_ctrl = m_ctrl;
        if (wr && a == `IO_TMR_CTRL_ADDR) begin
            next_ctrl.run = write_data[0];
            next_ctrl.irq_en = write_data[1];
            next_ctrl.auto_reload = write_data[3];
        end else if (expired && !m_ctrl.auto_reload) begin
            next_ctrl.run = 1'b0;
        end
        next_ctrl.pending = expired ||
            (m_ctrl.pending && !(wr && a == `IO_TMR_CTRL_ADDR && write_data[2]));
        if (wr && a == `IO_TMR_DATA_ADDR) begin
            m_reload = write_data;
            m_count = write_data;
        end else if (expired) begin
            if (m_ctrl.auto_reload) begin
                m_count = m_reload;
            end
        end else if (m_ctrl.run) begin
            m_count = m_count - 32'd1;
        end
        m_ctrl = next_ctrl;
        if (wr && a == `IO_LED_ADDR) begin
            m_led = write_data[8:0];
        end
        if (wr && a == `IO_HEX_ADDR) begin
            m_hex = write_data[23:0];
        end
        if (m_lcd_active) begin
            m_lcd_age++;
            if (m_lcd_age == LCD_TOTAL) begin
                m_lcd_active = 1'b0;
            end
        end else if (wr && (a == `IO_LCD_CMD_ADDR || a == `IO_LCD_DATA_ADDR)) begin
            m_lcd_active = 1'b1;
            m_lcd_age = 0;
            m_lcd_latched = {a == `IO_LCD_DATA_ADDR, write_data[7:0]};
            accepted.push_back(m_lcd_latched);
            accepted_count++;
        end
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs();
        logic [8:0] front;
        compare(32'(led), 32'(m_led), "led");
        for (int k = 0; k < 6; k++) begin
            compare(32'(hex[k]), 32'(seg_table[m_hex[4*k +: 4]]), $sformatf("hex%0d", k));
        end
        compare(32'(irq), 32'(m_irq), "irq");
        compare(32'(lcd_e), 32'(lcd_phase(m_lcd_active, m_lcd_age) == pulse), "lcd_e");
        if (m_lcd_active) begin
            compare(32'({lcd_rs, lcd_data}), 32'(m_lcd_latched), "lcd rs and data");
        end
        if (last_e && !lcd_e) begin
            pulse_count++;
            assert (accepted.size() != 0) else begin
                $display("lcd_e fell at %0t without any accepted write left", $time);
                errors++;
            end
            if (accepted.size() != 0) begin
                front = accepted.pop_front();
                compare(32'({lcd_rs, lcd_data}), 32'(front), "lcd write at falling e");
            end
        end
        last_e = lcd_e;
    endtask

    // one bus cycle, inputs driven on the falling edge
    task automatic bus_cycle(input logic sel, input logic stb, input logic wr,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rd);
        logic [31:0] r;
        r = next_random();
        io_select  = sel;
        strobe     = stb;
        write      = wr;
        address    = addr;
        write_data = wdata;
        sw         = r[9:0];
        #1;
        rd = read_data;
        compare(read_data, expected_read(), $sformatf("read_data at address %h", addr));
        advance_model();
        @(posedge clock);
        @(negedge clock);
        check_outputs();
    endtask

    task automatic random_access();
        logic [31:0] rd;
        logic [31:0] upper;
        logic [31:0] value;
        logic [15:0] offset;
        logic [2:0]  pick;
        logic        sel_bit;
        int unsigned kind;
        upper = next_random();   // bits 31:16 are not decoded
        value = next_random();
        kind = random_below(16);
        case (kind)
            0, 1: bus_cycle(1'b1, 1'b1, 1'b0, {upper[31:16], `IO_SW_ADDR}, value, rd);
            2: bus_cycle(1'b1, 1'b1, 1'b1, {upper[31:16], `IO_LED_ADDR}, value, rd);
            3: bus_cycle(1'b1, 1'b1, 1'b1, {upper[31:16], `IO_HEX_ADDR}, value, rd);
            4, 5: begin
                offset = upper[15:0];
                if (is_mapped(offset)) begin
                    offset = offset ^ 16'h0002;
                end
                bus_cycle(1'b1, 1'b1, kind == 5, {upper[31:16], offset}, value, rd);
            end
            6: begin
                pick = 3'(random_below(7));
                sel_bit = random_below(2) == 1;   // one of the two strobes is low
                bus_cycle(sel_bit, !sel_bit, value[20], {upper[31:16], offsets[pick]},
                          value, rd);
            end
            7, 8, 9, 10: bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_TMR_DATA_ADDR}, value, rd);
            14: begin
                if (random_below(4) != 0) begin
                    bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_TMR_CTRL_ADDR}, value, rd);
                end else if (value[24]) begin
                    bus_cycle(1'b1, 1'b1, 1'b1, {16'h0, `IO_TMR_DATA_ADDR},
                              32'(1 + random_below(40)), rd);
                end else begin
                    bus_cycle(1'b1, 1'b1, 1'b1, {16'h0, `IO_TMR_CTRL_ADDR},
                              32'(random_below(16)), rd);
                end
            end
            15: bus_cycle(1'b0, 1'b0, 1'b0, upper, value, rd);
            default: bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_TMR_CTRL_ADDR}, value, rd);
        endcase
    endtask

    task automatic wait_lcd_idle();
        logic [31:0] rd;
        rd = 32'd1;
        while (rd[0]) begin
            bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_LCD_CMD_ADDR}, 32'd0, rd);
        end
    endtask

    task automatic lcd_write();
        logic [31:0] rd;
        logic [31:0] value;
        value = next_random();
        bus_cycle(1'b1, 1'b1, 1'b1,
                  value[20] ? {16'h0, `IO_LCD_DATA_ADDR} : {16'h0, `IO_LCD_CMD_ADDR},
                  value, rd);
    endtask

    initial begin
        logic [31:0] rd;
        rng_state = 32'h45c3_a481;
        reset = 1'b1;
        sw = 10'd0;
        io_select = 1'b0;
        strobe = 1'b0;
        write = 1'b0;
        address = 32'd0;
        write_data = 32'd0;
        seg_table = '{`SEG_0, `SEG_1, `SEG_2, `SEG_3, `SEG_4, `SEG_5, `SEG_6, `SEG_7,
                      `SEG_8, `SEG_9, `SEG_A, `SEG_B, `SEG_C, `SEG_D, `SEG_E, `SEG_F};
        offsets = '{`IO_SW_ADDR, `IO_LED_ADDR, `IO_HEX_ADDR, `IO_LCD_CMD_ADDR,
                    `IO_LCD_DATA_ADDR, `IO_TMR_DATA_ADDR, `IO_TMR_CTRL_ADDR};
        m_led = 9'd0;
        m_hex = 24'd0;
        m_reload = 32'd0;
        m_count = 32'd0;
        m_ctrl = '0;
        m_irq = 1'b0;
        m_lcd_active = 1'b0;
        m_lcd_age = 0;
        m_lcd_latched = 9'd0;
        last_e = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_outputs();
        bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_TMR_CTRL_ADDR}, 32'd0, rd);
        compare(rd, 32'd0, "timer control after reset");
        bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_LCD_CMD_ADDR}, 32'd0, rd);
        compare(rd, 32'd0, "lcd busy after reset");

        // one-shot countdown, then clear pending by writing 1 to it
        bus_cycle(1'b1, 1'b1, 1'b1, {16'h0, `IO_TMR_DATA_ADDR}, 32'd5, rd);
        bus_cycle(1'b1, 1'b1, 1'b1, {16'h0, `IO_TMR_CTRL_ADDR}, 32'h3, rd);
        repeat (10) bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_TMR_CTRL_ADDR}, 32'd0, rd);
        compare(rd, 32'h6, "timer control after one-shot expiry");
        bus_cycle(1'b1, 1'b1, 1'b1, {16'h0, `IO_TMR_CTRL_ADDR}, 32'h4, rd);
        bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_TMR_CTRL_ADDR}, 32'd0, rd);
        compare(rd, 32'h0, "timer control after pending clear");
        bus_cycle(1'b1, 1'b1, 1'b1, {16'h0, `IO_TMR_DATA_ADDR}, 32'd3, rd);
        bus_cycle(1'b1, 1'b1, 1'b1, {16'h0, `IO_TMR_CTRL_ADDR}, 32'hB, rd);
        repeat (20) bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_TMR_DATA_ADDR}, 32'd0, rd);

        for (int i = 0; i < 1500; i++) begin
            random_access();
        end

        for (int n = 0; n < 40; n++) begin
            wait_lcd_idle();
            lcd_write();
            if (random_below(2) == 0) begin
                repeat (random_below(30)) begin
                    bus_cycle(1'b1, 1'b1, 1'b0, {16'h0, `IO_LCD_CMD_ADDR}, 32'd0, rd);
                end
                lcd_write();   // lands while busy and is dropped
            end
        end
        wait_lcd_idle();
        compare(32'(pulse_count), 32'(accepted_count), "lcd pulse count");
        compare(32'(accepted.size()), 32'd0, "lcd writes never shown");

        $display("%0d errors, %0d lcd writes accepted, %0d lcd pulses",
                 errors, accepted_count, pulse_count);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: hw/io_handler.sv
`timescale 1ns/1ps
`include "io_defs.svh"

module io_handler (
    input  logic         clock,
    input  logic         reset,
    input  logic [9:0]   sw,
    input  logic         io_select,
    input  logic         strobe,
    input  logic         write,
    input  logic [31:0]  address,
    input  logic [31:0]  write_data,
    output logic [31:0]  read_data,
    output logic [8:0]   led,
    output io_pkg::seg_t hex0,
    output io_pkg::seg_t hex1,
    output io_pkg::seg_t hex2,
    output io_pkg::seg_t hex3,
    output io_pkg::seg_t hex4,
    output io_pkg::seg_t hex5,
    output logic [7:0]   lcd_data,
    output logic         lcd_rs,
    output logic         lcd_e,
    output logic         irq
);

    logic        access;
    logic        sw_sel;
    logic        led_sel;
    logic        hex_sel;
    logic        lcd_cmd_sel;
    logic        lcd_data_sel;
    logic        tmr_data_sel;
    logic        tmr_ctrl_sel;
    logic        hex_write;
    logic        lcd_request;
    logic        lcd_rs_req;
    logic        lcd_busy;
    logic [31:0] tmr_read_data;

    assign access = io_select && strobe;

    // one select per register, high only in the access cycle
    always_comb begin
        sw_sel       = 1'b0;
        led_sel      = 1'b0;
        hex_sel      = 1'b0;
        lcd_cmd_sel  = 1'b0;
        lcd_data_sel = 1'b0;
        tmr_data_sel = 1'b0;
        tmr_ctrl_sel = 1'b0;
        if (access) begin
            case (address[15:0])
                `IO_SW_ADDR:       sw_sel       = 1'b1;
                `IO_LED_ADDR:      led_sel      = 1'b1;
                `IO_HEX_ADDR:      hex_sel      = 1'b1;
                `IO_LCD_CMD_ADDR:  lcd_cmd_sel  = 1'b1;
                `IO_LCD_DATA_ADDR: lcd_data_sel = 1'b1;
                `IO_TMR_DATA_ADDR: tmr_data_sel = 1'b1;
                `IO_TMR_CTRL_ADDR: tmr_ctrl_sel = 1'b1;
                default: ;
            endcase
        end
    end

    assign hex_write   = hex_sel && write;
    assign lcd_request = (lcd_cmd_sel || lcd_data_sel) && write;
    assign lcd_rs_req  = lcd_data_sel;   // rs high for character data, low for commands

    always_ff @(posedge clock) begin
        if (reset) begin
            led <= 9'd0;
        end else if (led_sel && write) begin
            led <= write_data[8:0];
        end
    end

    always_comb begin
        read_data = 32'd0;
        if (!write) begin
            if (sw_sel) begin
                read_data = {22'd0, sw};
            end else if (lcd_cmd_sel) begin
                read_data = {31'd0, lcd_busy};   // software polls this before each write
            end else if (tmr_data_sel || tmr_ctrl_sel) begin
                read_data = tmr_read_data;
            end
        end
    end

    hex_display u_hex_display (
        .clock     (clock),
        .reset     (reset),
        .hex_write (hex_write),
        .value     (write_data[23:0]),
        .digit0    (hex0),
        .digit1    (hex1),
        .digit2    (hex2),
        .digit3    (hex3),
        .digit4    (hex4),
        .digit5    (hex5)
    );

    interval_timer u_interval_timer (
        .clock      (clock),
        .reset      (reset),
        .data_sel   (tmr_data_sel),
        .ctrl_sel   (tmr_ctrl_sel),
        .write      (write),
        .write_data (write_data),
        .read_data  (tmr_read_data),
        .irq        (irq)
    );

    lcd_controller u_lcd_controller (
        .clock    (clock),
        .reset    (reset),
        .request  (lcd_request),
        .rs_in    (lcd_rs_req),
        .data_in  (write_data[7:0]),
        .busy     (lcd_busy),
        .lcd_rs   (lcd_rs),
        .lcd_e    (lcd_e),
        .lcd_data (lcd_data)
    );

endmodule

// File: hw/lcd_controller.sv
`timescale 1ns/1ps
`include "io_defs.svh"

module lcd_controller (
    input  logic       clock,
    input  logic       reset,
    input  logic       request,
    input  logic       rs_in,
    input  logic [7:0] data_in,
    output logic       busy,
    output logic       lcd_rs,
    output logic       lcd_e,
    output logic [7:0] lcd_data
);
    import io_pkg::*;

    lcd_state_e state;
    logic [4:0] counter;   // cycles left in the current phase, minus one

    assign busy = (state != idle);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= idle;
            counter  <= 5'd0;
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= 8'd0;
        end else begin
            case (state)
                idle: begin
                    if (request) begin
                        state    <= setup;
                        counter  <= 5'(`LCD_SETUP - 1);
                        lcd_rs   <= rs_in;   // held until the write completes
                        lcd_data <= data_in;
                    end
                end
                setup: begin
                    if (counter == 5'd0) begin
                        state   <= pulse;
                        counter <= 5'(`LCD_PULSE - 1);
                        lcd_e   <= 1'b1;
                    end else begin
                        counter <= counter - 5'd1;
                    end
                end
                pulse: begin
                    if (counter == 5'd0) begin
                        state   <= hold;
                        counter <= 5'(`LCD_HOLD - 1);
                        lcd_e   <= 1'b0;   // the display latches on this falling edge
                    end else begin
                        counter <= counter - 5'd1;
                    end
                end
                hold: begin
                    if (counter == 5'd0) begin
                        state <= idle;
                    end else begin
                        counter <= counter - 5'd1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// File: hw/interval_timer.sv
`timescale 1ns/1ps

module interval_timer (
    input  logic        clock,
    input  logic        reset,
    input  logic        data_sel,
    input  logic        ctrl_sel,
    input  logic        write,
    input  logic [31:0] write_data,
    output logic [31:0] read_data,
    output logic        irq
);
    import io_pkg::*;

    logic [31:0] reload_value;
    logic [31:0] count;
    timer_ctrl_t ctrl;
    timer_ctrl_t written;
    logic        data_write;
    logic        ctrl_write;
    logic        expired;

    assign data_write = data_sel && write;
    assign ctrl_write = ctrl_sel && write;
    assign written    = timer_ctrl_t'(write_data[3:0]);

    // count has reached zero while running
    assign expired = ctrl.run && (count == 32'd0);

    always_ff @(posedge clock) begin
        if (reset) begin
            reload_value <= 32'd0;
        end else if (data_write) begin
            reload_value <= write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= 32'd0;
        end else if (data_write) begin
            count <= write_data;   // a data write restarts the countdown
        end else if (expired) begin
            if (ctrl.auto_reload) begin
                count <= reload_value;
            end
        end else if (ctrl.run) begin
            count <= count - 32'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl <= '0;
        end else begin
            if (ctrl_write) begin
                ctrl.run         <= written.run;
                ctrl.irq_en      <= written.irq_en;
                ctrl.auto_reload <= written.auto_reload;
            end else if (expired && !ctrl.auto_reload) begin
                ctrl.run <= 1'b0;   // one-shot mode stops at zero
            end
            // a new expiry beats a clear in the same cycle
            ctrl.pending <= expired || (ctrl.pending && !(ctrl_write && written.pending));
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= ctrl.pending && ctrl.irq_en;
        end
    end

    always_comb begin
        if (data_sel) begin
            read_data = count;
        end else if (ctrl_sel) begin
            read_data = {28'd0, ctrl};
        end else begin
            read_data = 32'd0;
        end
    end

endmodule

// File: hw/hex_display.sv
`timescale 1ns/1ps
`include "io_defs.svh"

module hex_display (
    input  logic         clock,
    input  logic         reset,
    input  logic         hex_write,
    input  logic [23:0]  value,
    output io_pkg::seg_t digit0,
    output io_pkg::seg_t digit1,
    output io_pkg::seg_t digit2,
    output io_pkg::seg_t digit3,
    output io_pkg::seg_t digit4,
    output io_pkg::seg_t digit5
);
    import io_pkg::*;

    seg_t digit_q [6];

    function automatic seg_t encode(input logic [3:0] nibble);
        seg_t pattern;
        case (nibble)
            4'h0: pattern = `SEG_0;
            4'h1: pattern = `SEG_1;
            4'h2: pattern = `SEG_2;
            4'h3: pattern = `SEG_3;
            4'h4: pattern = `SEG_4;
            4'h5: pattern = `SEG_5;
            4'h6: pattern = `SEG_6;
            4'h7: pattern = `SEG_7;
            4'h8: pattern = `SEG_8;
            4'h9: pattern = `SEG_9;
            4'hA: pattern = `SEG_A;
            4'hB: pattern = `SEG_B;
            4'hC: pattern = `SEG_C;
            4'hD: pattern = `SEG_D;
            4'hE: pattern = `SEG_E;
            default: pattern = `SEG_F;
        endcase
        return pattern;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < 6; k++) begin
                digit_q[k] <= `SEG_0;   // display reads 000000 out of reset
            end
        end else if (hex_write) begin
            for (int k = 0; k < 6; k++) begin
                digit_q[k] <= encode(value[4*k +: 4]);   // digit k shows nibble k
            end
        end
    end

    assign digit0 = digit_q[0];
    assign digit1 = digit_q[1];
    assign digit2 = digit_q[2];
    assign digit3 = digit_q[3];
    assign digit4 = digit_q[4];
    assign digit5 = digit_q[5];

endmodule

// File: hw/io_pkg.sv
package io_pkg;

    // one seven-segment digit, active low
    typedef logic [6:0] seg_t;

    // interval timer control word as seen on the bus
    typedef struct packed {
        logic auto_reload;   // bit 3
        logic pending;       // bit 2, write 1 to clear
        logic irq_en;        // bit 1
        logic run;           // bit 0
    } timer_ctrl_t;

    // phases of one LCD write
    typedef enum logic [1:0] {
        idle,
        setup,
        pulse,
        hold
    } lcd_state_e;

endpackage

// File: hw/io_defs.svh
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// register offsets, only address bits 15:0 are decoded
`define IO_SW_ADDR        16'h0000
`define IO_LED_ADDR       16'h0004
`define IO_HEX_ADDR       16'h0008
`define IO_LCD_CMD_ADDR   16'h000C
`define IO_LCD_DATA_ADDR  16'h0010
`define IO_TMR_DATA_ADDR  16'h0100
`define IO_TMR_CTRL_ADDR  16'h0104

// segment patterns, active low, bit 6 is segment g and bit 0 is segment a
`define SEG_0  7'b1000000
`define SEG_1  7'b1111001
`define SEG_2  7'b0100100
`define SEG_3  7'b0110000
`define SEG_4  7'b0011001
`define SEG_5  7'b0010010
`define SEG_6  7'b0000010
`define SEG_7  7'b1111000
`define SEG_8  7'b0000000
`define SEG_9  7'b0010000
`define SEG_A  7'b0001000
`define SEG_B  7'b0000011   // lower-case b
`define SEG_C  7'b1000110
`define SEG_D  7'b0100001   // lower-case d
`define SEG_E  7'b0000110
`define SEG_F  7'b0001110

// LCD write timing in clock cycles
// address and data settle before e rises
`define LCD_SETUP  4
`define LCD_PULSE  12
// the HD44780 needs time to digest each write before the next one
`define LCD_HOLD   20

`endif
